// File: build.f
fp_noncomp_pkg.sv
fp_lane_req_if.sv
fp_lane_distribute.sv
fp_lane_noncomp.sv
fp_lane_pipe.sv
fp_result_pack.sv
fp_noncomp_slice.sv
tb_fp_noncomp_slice.sv

// File: Bender.yml
package:
  name: fp_noncomp_slice

dependencies: {}

sources:
  # RTL in compile order
  - fp_noncomp_pkg.sv
  - fp_lane_req_if.sv
  - fp_lane_distribute.sv
  - fp_lane_noncomp.sv
  - fp_lane_pipe.sv
  - fp_result_pack.sv
  - fp_noncomp_slice.sv

  - target: test
    files:
      - tb_fp_noncomp_slice.sv

// File: tb_fp_noncomp_slice.sv
// Runs with NumPipeRegs 2 and EnableVectors 1; the latency check assumes exactly 2 register stages
`default_nettype none

module tb_fp_noncomp_slice;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD = 10;
  localparam int unsigned PIPE_REGS  = 2;
  localparam int unsigned N_LATENCY  = 5;
  localparam int unsigned N_SGNJ32   = 40;
  localparam int unsigned N_FP16S    = 30;
  localparam int unsigned N_VECTOR   = 31;
  localparam int unsigned N_SPECIAL  = 16;
  localparam int unsigned N_BACKPR   = 80;
  localparam int unsigned TOTAL_OPS  = N_LATENCY + N_SGNJ32 + N_FP16S + N_VECTOR
                                       + N_SPECIAL + N_BACKPR;

  typedef struct {
    logic [31:0] result;
    logic [4:0]  status;
    logic [7:0]  tag;
    int          cycle;   // Edge at which the input was accepted
    bit          stalled; // Saw out_ready_i low while in flight
  } expect_t;

  logic                       clk_i;
  logic                       arst_n_i;
  logic [31:0]                operands_a_i;
  logic [31:0]                operands_b_i;
  fp_noncomp_pkg::operation_e op_i;
  fp_noncomp_pkg::fp_format_e fmt_i;
  logic                       vectorial_op_i;
  logic [7:0]                 tag_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  logic [31:0]                result_o;
  fp_noncomp_pkg::status_t    status_o;
  logic [7:0]                 tag_o;
  logic                       out_valid_o;
  logic                       out_ready_i;
  logic                       busy_o;

  integer  seed;
  integer  ready_seed;
  expect_t exp_q[$];
  expect_t held;
  bit      hold_check;
  bit      random_ready;
  int      cycle;
  int      errors;
  int      base_errors;
  int      tests;
  int      checked;
  logic [7:0] tag_count;

  fp_noncomp_slice #(
    .NumPipeRegs   (PIPE_REGS),
    .EnableVectors (1'b1)
  ) uut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .operands_a_i   (operands_a_i),
    .operands_b_i   (operands_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .result_o       (result_o),
    .status_o       (status_o),
    .tag_o          (tag_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .busy_o         (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Returns {nv, result}; FP16 operands and results use the low 16 bits
  function automatic logic [32:0] lane_model(logic [2:0] op, logic [31:0] a, logic [31:0] b,
                                             bit is16);
    int unsigned msb;
    logic [31:0] mask;
    logic [31:0] key_a;
    logic [31:0] key_b;
    logic [31:0] res;
    logic        a_nan;
    logic        b_nan;
    logic        a_snan;
    logic        b_snan;
    logic        nv;
    msb  = is16 ? 15 : 31;
    mask = is16 ? 32'h0000_ffff : 32'hffff_ffff;
    a    = a & mask;
    b    = b & mask;
    if (is16) begin
      a_nan  = (a[14:10] == 5'h1f) && (a[9:0] != 0);
      b_nan  = (b[14:10] == 5'h1f) && (b[9:0] != 0);
      a_snan = a_nan && !a[9];
      b_snan = b_nan && !b[9];
    end else begin
      a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 0);
      b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 0);
      a_snan = a_nan && !a[22];
      b_snan = b_nan && !b[22];
    end
    // Order-preserving unsigned keys put -0 just below +0
    key_a = a[msb] ? (~a & mask) : (a | (32'h1 << msb));
    key_b = b[msb] ? (~b & mask) : (b | (32'h1 << msb));
    nv    = 1'b0;
    res   = a;
    case (op)
      fp_noncomp_pkg::SGNJ:  res[msb] = b[msb];
      fp_noncomp_pkg::SGNJN: res[msb] = ~b[msb];
      fp_noncomp_pkg::SGNJX: res[msb] = a[msb] ^ b[msb];
      default: begin
        nv = a_snan | b_snan;
        if (a_nan && b_nan) begin
          res = is16 ? {16'h0, fp_noncomp_pkg::CANON_NAN16} : fp_noncomp_pkg::CANON_NAN32;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else if (op == fp_noncomp_pkg::MIN) begin
          res = (key_a < key_b) ? a : b;
        end else begin
          res = (key_a > key_b) ? a : b;
        end
      end
    endcase
    return {nv, res & mask};
  endfunction

  function automatic expect_t word_model(logic [31:0] a, logic [31:0] b, logic [2:0] op,
                                         logic fmt, logic vec, logic [7:0] tag);
    expect_t     e;
    logic [32:0] lo;
    logic [32:0] hi;
    e.tag     = tag;
    e.cycle   = cycle;
    e.stalled = 1'b0;
    if (fmt == fp_noncomp_pkg::FP32) begin
      lo       = lane_model(op, a, b, 1'b0); // Vector flag has no effect here
      e.result = lo[31:0];
      e.status = {lo[32], 4'b0};
    end else begin
      lo = lane_model(op, {16'h0, a[15:0]}, {16'h0, b[15:0]}, 1'b1);
      hi = lane_model(op, {16'h0, a[31:16]}, {16'h0, b[31:16]}, 1'b1);
      if (vec) begin
        e.result = {hi[15:0], lo[15:0]};
        e.status = {lo[32] | hi[32], 4'b0};
      end else begin
        e.result = {16'hffff, lo[15:0]}; // NaN-box
        e.status = {lo[32], 4'b0};
      end
    end
    return e;
  endfunction

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    $display("MISMATCH %s: expected %h, got %h at %0t", name, expected, actual, $time);
    errors++;
  endtask

  task automatic report_failure(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(string name, int ops);
    tests++;
    $display("%-16s %0d ops, %0d errors", name, ops, errors - base_errors);
    base_errors = errors;
  endtask

  // ----------------------------------------
  // Scoreboard and checks sampled at the rising edge
  // ----------------------------------------
  always @(posedge clk_i) begin : monitor
    expect_t exp;
    logic    exp_ready;
    if (arst_n_i) begin
      if (hold_check) begin
        assert (out_valid_o) else report_failure("out_valid_o dropped while stalled");
        assert (result_o == held.result) else report_mismatch("result_o", held.result, result_o);
        assert (status_o == held.status) else report_mismatch("status_o", held.status, status_o);
        assert (tag_o == held.tag) else report_mismatch("tag_o", held.tag, tag_o);
      end
      assert (busy_o == (exp_q.size() != 0))
        else report_mismatch("busy_o", exp_q.size() != 0, busy_o);
      // Input stalls only when every stage holds an item that cannot leave
      exp_ready = !(exp_q.size() == PIPE_REGS && !out_ready_i);
      assert (in_ready_o == exp_ready)
        else report_mismatch("in_ready_o", exp_ready, in_ready_o);
      assert (!out_valid_o || exp_q.size() != 0)
        else report_failure("out_valid_o high with no input in flight");
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        checked++;
        assert (result_o == exp.result) else report_mismatch("result_o", exp.result, result_o);
        assert (status_o == exp.status) else report_mismatch("status_o", exp.status, status_o);
        assert (tag_o == exp.tag) else report_mismatch("tag_o", exp.tag, tag_o);
        assert (exp.stalled || cycle - exp.cycle == PIPE_REGS)
          else report_failure($sformatf("result came %0d cycles after its input instead of %0d",
                                        cycle - exp.cycle, PIPE_REGS));
      end
      if (!out_ready_i) begin
        foreach (exp_q[i]) exp_q[i].stalled = 1'b1;
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(word_model(operands_a_i, operands_b_i, op_i, fmt_i, vectorial_op_i,
                                   tag_i));
      end
      hold_check  = out_valid_o && !out_ready_i;
      held.result = result_o;
      held.status = status_o;
      held.tag    = tag_o;
    end
    cycle++;
  end

  always @(posedge clk_i) begin : ready_driver
    #1;
    out_ready_i = random_ready ? (($unsigned($random(ready_seed)) % 4) != 0) : 1'b1;
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Mostly random bits with signed zeros and both NaN kinds mixed in
  function automatic logic [31:0] random_operand(bit is16);
    logic [31:0] r;
    logic [31:0] v;
    r = $random(seed);
    v = $random(seed);
    case (r[2:0])
      3'd0: v = is16 ? {v[31:16], v[15], 15'h0} : {v[31], 31'h0};
      3'd1: v = is16 ? {v[31:16], v[15], 5'h1f, 1'b1, v[8:0]} : {v[31], 8'hff, 1'b1, v[21:0]};
      3'd2: v = is16 ? {v[31:16], v[15], 5'h1f, 1'b0, v[8:1], 1'b1}
                     : {v[31], 8'hff, 1'b0, v[21:1], 1'b1};
      default: ;
    endcase
    return v;
  endfunction

  function automatic logic [2:0] random_op(bit with_minmax);
    return with_minmax ? 3'($unsigned($random(seed)) % 5) : 3'($unsigned($random(seed)) % 3);
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic send_op(logic [31:0] a, logic [31:0] b, logic [2:0] op, logic fmt, logic vec);
    operands_a_i   = a;
    operands_b_i   = b;
    op_i           = fp_noncomp_pkg::operation_e'(op);
    fmt_i          = fp_noncomp_pkg::fp_format_e'(fmt);
    vectorial_op_i = vec;
    tag_i          = tag_count;
    in_valid_i     = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
    tag_count++;
  endtask

  task automatic drain();
    do begin
      @(posedge clk_i);
      #1;
    end while (exp_q.size() != 0);
  endtask

  task automatic send_fp16_vector(logic [2:0] op);
    logic [31:0] a_hi;
    logic [31:0] a_lo;
    logic [31:0] b_hi;
    logic [31:0] b_lo;
    a_hi = random_operand(1'b1);
    a_lo = random_operand(1'b1);
    b_hi = random_operand(1'b1);
    b_lo = random_operand(1'b1);
    send_op({a_hi[15:0], a_lo[15:0]}, {b_hi[15:0], b_lo[15:0]}, op, 1'b1, 1'b1);
  endtask

  initial begin : watchdog
    #((TOTAL_OPS * 20 + 100) * CLK_PERIOD);
    $display("ERROR: timeout, the run did not finish in time");
    $display("test failed");
    $finish;
  end

  initial begin : main
    seed           = 32'h8964_9793;
    ready_seed     = ~32'h8964_9793;
    arst_n_i       = 1'b0;
    operands_a_i   = '0;
    operands_b_i   = '0;
    op_i           = fp_noncomp_pkg::SGNJ;
    fmt_i          = fp_noncomp_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    random_ready   = 1'b0;
    hold_check     = 1'b0;
    cycle          = 0;
    errors         = 0;
    base_errors    = 0;
    tests          = 0;
    checked        = 0;
    tag_count      = '0;
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Reset state then back-to-back latency
    assert (!out_valid_o) else report_mismatch("out_valid_o", 0, out_valid_o);
    assert (!busy_o) else report_mismatch("busy_o", 0, busy_o);
    assert (in_ready_o) else report_mismatch("in_ready_o", 1, in_ready_o);
    for (int i = 0; i < N_LATENCY - 1; i++) begin
      send_op(random_operand(1'b0), random_operand(1'b0), random_op(1'b0), 1'b0, 1'b0);
    end
    repeat (3) @(posedge clk_i);
    #1;
    send_op(32'h3f80_0000, 32'hc000_0000, fp_noncomp_pkg::SGNJ, 1'b0, 1'b0);
    drain();
    end_test("reset_latency", N_LATENCY);

    for (int i = 0; i < N_SGNJ32; i++) begin
      send_op(random_operand(1'b0), random_operand(1'b0), random_op(1'b0), 1'b0, i[0]);
    end
    drain();
    end_test("fp32_sgnj", N_SGNJ32);

    // Upper operand bits are random and must not leak into the result
    for (int i = 0; i < N_FP16S; i++) begin
      send_op(random_operand(1'b1), random_operand(1'b1), random_op(1'b1), 1'b1, 1'b0);
    end
    drain();
    end_test("fp16_scalar", N_FP16S);

    send_op({16'h7d00, 16'h3c00}, {16'h4000, 16'h3c00}, fp_noncomp_pkg::MIN, 1'b1, 1'b1);
    for (int i = 0; i < N_VECTOR - 1; i++) begin
      send_fp16_vector(random_op(1'b1));
    end
    drain();
    end_test("fp16_vector", N_VECTOR);

    // ---- NaN, signed zero and sNaN cases
    send_op(32'h7fc0_0001, 32'h3f80_0000, fp_noncomp_pkg::MIN, 1'b0, 1'b0);
    send_op(32'h3f80_0000, 32'hffc0_0000, fp_noncomp_pkg::MAX, 1'b0, 1'b0);
    send_op(32'h7fc0_0001, 32'h7f80_0001, fp_noncomp_pkg::MIN, 1'b0, 1'b0);
    send_op(32'hffc0_0000, 32'h7fc0_0000, fp_noncomp_pkg::MAX, 1'b0, 1'b0);
    send_op(32'h0000_0000, 32'h8000_0000, fp_noncomp_pkg::MIN, 1'b0, 1'b0);
    send_op(32'h0000_0000, 32'h8000_0000, fp_noncomp_pkg::MAX, 1'b0, 1'b0);
    send_op(32'h7f80_0001, 32'h3f80_0000, fp_noncomp_pkg::MAX, 1'b0, 1'b0);
    send_op(32'hbf80_0000, 32'hff80_0001, fp_noncomp_pkg::MIN, 1'b0, 1'b0);
    send_op(32'h0000_7e01, 32'h0000_3c00, fp_noncomp_pkg::MIN, 1'b1, 1'b0);
    send_op(32'h0000_bc00, 32'h0000_fe00, fp_noncomp_pkg::MAX, 1'b1, 1'b0);
    send_op(32'h0000_7e01, 32'h0000_7c01, fp_noncomp_pkg::MIN, 1'b1, 1'b0);
    send_op(32'h1234_7c01, 32'h5678_fe00, fp_noncomp_pkg::MAX, 1'b1, 1'b0);
    send_op(32'h0000_0000, 32'h0000_8000, fp_noncomp_pkg::MIN, 1'b1, 1'b0);
    send_op(32'h0000_8000, 32'h0000_0000, fp_noncomp_pkg::MAX, 1'b1, 1'b0);
    send_op(32'h0000_7c01, 32'h0000_4000, fp_noncomp_pkg::MAX, 1'b1, 1'b0);
    send_op({16'h8000, 16'h7d00}, {16'h0000, 16'h3c00}, fp_noncomp_pkg::MIN, 1'b1, 1'b1);
    drain();
    end_test("minmax_specials", N_SPECIAL);

    random_ready = 1'b1;
    for (int i = 0; i < N_BACKPR; i++) begin
      if (i % 3 == 2) begin
        send_fp16_vector(random_op(1'b1));
      end else begin
        send_op(random_operand(i[0]), random_operand(i[0]), random_op(1'b1), i[0], i[1]);
      end
    end
    drain();
    random_ready = 1'b0;
    end_test("backpressure", N_BACKPR);

    $display("%0d tests, %0d results checked, %0d errors", tests, checked, errors);
    if (errors == 0 && checked == TOTAL_OPS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fp_noncomp_slice.sv
// Sign injection and MIN/MAX only; lane pipes share one handshake and stay in lockstep
`default_nettype none

module fp_noncomp_slice #(
  parameter int unsigned NumPipeRegs   = 2,
  parameter bit          EnableVectors = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [fp_noncomp_pkg::FLEN-1:0]     operands_a_i,
  input  logic [fp_noncomp_pkg::FLEN-1:0]     operands_b_i,
  input  fp_noncomp_pkg::operation_e          op_i,
  input  fp_noncomp_pkg::fp_format_e          fmt_i,
  input  logic                                vectorial_op_i,
  input  logic [fp_noncomp_pkg::TAG_BITS-1:0] tag_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  output logic [fp_noncomp_pkg::FLEN-1:0]     result_o,
  output fp_noncomp_pkg::status_t             status_o,
  output logic [fp_noncomp_pkg::TAG_BITS-1:0] tag_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic                                busy_o
);

  localparam int unsigned FLEN = fp_noncomp_pkg::FLEN;
  localparam int unsigned HLEN = fp_noncomp_pkg::HLEN;

  fp_noncomp_pkg::aux_t       aux;
  logic [FLEN-1:0]            lane0_result;
  fp_noncomp_pkg::status_t    lane0_status;
  logic [HLEN-1:0]            lane1_result;
  fp_noncomp_pkg::status_t    lane1_status;
  fp_noncomp_pkg::lane0_res_t lane0_d;
  fp_noncomp_pkg::lane0_res_t lane0_q;
  fp_noncomp_pkg::lane_res_t  lane1_d;
  fp_noncomp_pkg::lane_res_t  lane1_q;
  logic                       lane0_valid;

  fp_lane_req_if #(.Width(FLEN)) lane0_req ();
  fp_lane_req_if #(.Width(HLEN)) lane1_req ();

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  fp_lane_distribute #(
    .EnableVectors (EnableVectors)
  ) i_distribute (
    .operands_a_i   (operands_a_i),
    .operands_b_i   (operands_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .lane0_req_o    (lane0_req),
    .lane1_req_o    (lane1_req),
    .aux_o          (aux)
  );

  fp_lane_noncomp #(
    .LaneWidth (FLEN)
  ) i_lane0 (
    .req_i    (lane0_req),
    .result_o (lane0_result),
    .status_o (lane0_status)
  );

  if (EnableVectors) begin : g_lane1
    fp_lane_noncomp #(
      .LaneWidth (HLEN)
    ) i_lane1 (
      .req_i    (lane1_req),
      .result_o (lane1_result),
      .status_o (lane1_status)
    );
  end else begin : g_lane1_off
    assign lane1_result = '0;
    assign lane1_status = '0;
  end

  // Aux data and tag ride along with lane 0
  assign lane0_d = '{result: lane0_result, status: lane0_status, aux: aux, tag: tag_i};
  assign lane1_d = '{result: lane1_result, status: lane1_status};

  // ----------------------------------------
  // Lane pipelines
  // ----------------------------------------
  fp_lane_pipe #(
    .NumPipeRegs (NumPipeRegs),
    .payload_t   (fp_noncomp_pkg::lane0_res_t)
  ) i_pipe0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_i      (lane0_d),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_o      (lane0_q),
    .out_valid_o (lane0_valid),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  fp_lane_pipe #(
    .NumPipeRegs (NumPipeRegs),
    .payload_t   (fp_noncomp_pkg::lane_res_t)
  ) i_pipe1 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_i      (lane1_d),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (),                    // Same as lane 0
    .data_o      (lane1_q),
    .out_valid_o (),
    .out_ready_i (out_ready_i),
    .busy_o      ()
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  fp_result_pack #(
    .EnableVectors (EnableVectors)
  ) i_pack (
    .lane0_i       (lane0_q),
    .lane1_i       (lane1_q),
    .lane0_valid_i (lane0_valid),
    .result_o      (result_o),
    .status_o      (status_o),
    .tag_o         (tag_o),
    .out_valid_o   (out_valid_o)
  );

endmodule

`default_nettype wire

// File: fp_result_pack.sv
// Status is zero while lane 0 is not valid; lane 1 matters only for FP16 vector results
`default_nettype none

module fp_result_pack #(
  parameter bit EnableVectors = 1'b1
) (
  input  fp_noncomp_pkg::lane0_res_t               lane0_i,
  input  fp_noncomp_pkg::lane_res_t                lane1_i,
  input  logic                                     lane0_valid_i,
  output logic [fp_noncomp_pkg::FLEN-1:0]          result_o,
  output fp_noncomp_pkg::status_t                  status_o,
  output logic [fp_noncomp_pkg::TAG_BITS-1:0]      tag_o,
  output logic                                     out_valid_o
);

  localparam int unsigned HLEN = fp_noncomp_pkg::HLEN;

  fp_noncomp_pkg::aux_t    aux;
  logic [HLEN-1:0]         upper_res;
  fp_noncomp_pkg::status_t upper_status;

  assign aux = lane0_i.aux;

  if (EnableVectors) begin : g_upper
    assign upper_res    = lane1_i.result;
    assign upper_status = lane1_i.status;
  end else begin : g_upper_off
    assign upper_res    = '1; // No upper lane, box it
    assign upper_status = '0;
  end

  // ----------------------------------------
  // Word assembly
  // ----------------------------------------
  always_comb begin : pack
    if (aux.dst_fmt == fp_noncomp_pkg::FP32) begin
      result_o = lane0_i.result;
    end else if (aux.is_vector) begin
      result_o = {upper_res, lane0_i.result[HLEN-1:0]};
    end else begin
      result_o = {{HLEN{1'b1}}, lane0_i.result[HLEN-1:0]}; // NaN-box scalar FP16
    end
  end

  always_comb begin : collapse_status
    fp_noncomp_pkg::status_t lane_status;
    lane_status = lane0_i.status;
    if (aux.is_vector) begin
      lane_status = lane_status | upper_status;
    end
    status_o = lane0_valid_i ? lane_status : '0;
  end

  assign tag_o       = lane0_i.tag;
  assign out_valid_o = lane0_valid_i;

endmodule

`default_nettype wire

// File: fp_lane_pipe.sv
// NumPipeRegs of 0 gives a combinational path; payload registers carry no reset
`default_nettype none

module fp_lane_pipe #(
  parameter int unsigned NumPipeRegs = 0,
  parameter type         payload_t   = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  if (NumPipeRegs == 0) begin : g_bypass
    assign data_o      = data_i;
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;
    assign busy_o      = 1'b0; // Nothing is ever held
  end else begin : g_regs
    logic [NumPipeRegs-1:0] stage_valid;
    logic [NumPipeRegs-1:0] stage_load; // Stage can take its predecessor's item

    for (genvar i = 0; i < NumPipeRegs; i++) begin : g_stage
      payload_t data_q;
      logic     valid_q;
      payload_t src_data;
      logic     src_valid;
      logic     next_ready;

      if (i == 0) begin : g_src_in
        assign src_data  = data_i;
        assign src_valid = in_valid_i;
      end else begin : g_src_prev
        assign src_data  = g_stage[i-1].data_q;
        assign src_valid = stage_valid[i-1];
      end

      if (i == NumPipeRegs - 1) begin : g_last
        assign next_ready = out_ready_i;
      end else begin : g_mid
        assign next_ready = stage_load[i+1];
      end

      // Empty, or the item moves on this edge
      assign stage_load[i]  = ~valid_q | next_ready;
      assign stage_valid[i] = valid_q;

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          valid_q <= 1'b0;
        end else if (stage_load[i]) begin
          valid_q <= src_valid;
        end
      end

      always_ff @(posedge clk_i) begin
        if (stage_load[i] && src_valid) begin
          data_q <= src_data;
        end
      end
    end

    assign in_ready_o  = stage_load[0];
    assign data_o      = g_stage[NumPipeRegs-1].data_q;
    assign out_valid_o = stage_valid[NumPipeRegs-1];
    assign busy_o      = |stage_valid;
  end

endmodule

`default_nettype wire

// File: fp_lane_noncomp.sv
// LaneWidth is 32 or 16; a 16-bit lane treats every request as FP16, encodings 5..7 act as SGNJ
`default_nettype none

module fp_lane_noncomp #(
  parameter int unsigned LaneWidth = 32
) (
  fp_lane_req_if.lane                    req_i,
  output logic [LaneWidth-1:0]           result_o,
  output fp_noncomp_pkg::status_t        status_o
);

  typedef struct packed {
    logic        sign;
    logic        nan;
    logic        snan;
    logic [30:0] mag; // Magnitude bits, zero extended for FP16
  } operand_info_t;

  // Splits one operand into sign, magnitude and NaN class for the given format
  function automatic operand_info_t classify(logic [31:0] x, logic is16);
    operand_info_t info;
    if (is16) begin
      info.sign = x[15];
      info.nan  = (x[14:10] == 5'h1f) && (x[9:0] != 10'h0);
      info.snan = info.nan && !x[9]; // Quiet bit clear
      info.mag  = {16'h0, x[14:0]};
    end else begin
      info.sign = x[31];
      info.nan  = (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
      info.snan = info.nan && !x[22];
      info.mag  = x[30:0];
    end
    return info;
  endfunction

  fp_noncomp_pkg::operation_e op;
  logic                       is16;
  logic [31:0]                a;
  logic [31:0]                b;
  logic [31:0]                injected;
  logic [31:0]                canon_nan;
  logic [31:0]                res;
  operand_info_t              info_a;
  operand_info_t              info_b;
  logic                       sgn;
  logic                       a_lt_b;
  logic                       pick_a;

  assign op     = fp_noncomp_pkg::operation_e'(req_i.op);
  assign is16   = (LaneWidth == 16) || (req_i.fmt == fp_noncomp_pkg::FP16);
  assign a      = 32'(req_i.operand_a);
  assign b      = 32'(req_i.operand_b);
  assign info_a = classify(a, is16);
  assign info_b = classify(b, is16);

  assign canon_nan = is16 ? {16'h0, fp_noncomp_pkg::CANON_NAN16}
                          : fp_noncomp_pkg::CANON_NAN32;

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin : sign_inject
    case (op)
      fp_noncomp_pkg::SGNJN: sgn = ~info_b.sign;
      fp_noncomp_pkg::SGNJX: sgn = info_a.sign ^ info_b.sign;
      default:               sgn = info_b.sign;
    endcase
  end

  assign injected = is16 ? {16'h0, sgn, a[14:0]} : {sgn, a[30:0]};

  // ----------------------------------------
  // Ordering for MIN/MAX
  // ----------------------------------------
  // Sign decides first so -0 orders below +0
  always_comb begin : order
    if (info_a.sign != info_b.sign) begin
      a_lt_b = info_a.sign;
    end else if (info_a.sign) begin
      a_lt_b = info_a.mag > info_b.mag; // Both negative
    end else begin
      a_lt_b = info_a.mag < info_b.mag;
    end
  end

  assign pick_a = (op == fp_noncomp_pkg::MAX) ? ~a_lt_b : a_lt_b;

  always_comb begin : select_result
    status_o = '0;
    if (op == fp_noncomp_pkg::MIN || op == fp_noncomp_pkg::MAX) begin
      status_o.NV = info_a.snan | info_b.snan;
      if (info_a.nan && info_b.nan) begin
        res = canon_nan;
      end else if (info_a.nan) begin
        res = b; // A NaN loses to any number
      end else if (info_b.nan) begin
        res = a;
      end else begin
        res = pick_a ? a : b;
      end
    end else begin
      res = injected;
    end
  end

  assign result_o = res[LaneWidth-1:0];

endmodule

`default_nettype wire

// File: fp_lane_distribute.sv
// Lane 1 always sees bits 31:16; the vector flag survives only for FP16 with vectors enabled
`default_nettype none

module fp_lane_distribute #(
  parameter bit EnableVectors = 1'b1
) (
  input  logic [fp_noncomp_pkg::FLEN-1:0] operands_a_i,
  input  logic [fp_noncomp_pkg::FLEN-1:0] operands_b_i,
  input  fp_noncomp_pkg::operation_e      op_i,
  input  fp_noncomp_pkg::fp_format_e      fmt_i,
  input  logic                            vectorial_op_i,
  fp_lane_req_if.distributor              lane0_req_o,
  fp_lane_req_if.distributor              lane1_req_o,
  output fp_noncomp_pkg::aux_t            aux_o
);

  localparam int unsigned FLEN = fp_noncomp_pkg::FLEN;
  localparam int unsigned HLEN = fp_noncomp_pkg::HLEN;

  logic            is_fp16;
  logic            vector_op;
  logic [FLEN-1:0] low_mask; // Keeps only the active field for lane 0

  assign is_fp16   = (fmt_i == fp_noncomp_pkg::FP16);
  assign vector_op = vectorial_op_i & EnableVectors & is_fp16; // FP32 never runs as a vector
  assign low_mask  = is_fp16 ? 32'h0000_ffff : 32'hffff_ffff;

  // ----------------------------------------
  // Lane slicing
  // ----------------------------------------
  assign lane0_req_o.operand_a = operands_a_i & low_mask;
  assign lane0_req_o.operand_b = operands_b_i & low_mask;
  assign lane0_req_o.op        = op_i;
  assign lane0_req_o.fmt       = fmt_i;

  assign lane1_req_o.operand_a = operands_a_i[FLEN-1:HLEN];
  assign lane1_req_o.operand_b = operands_b_i[FLEN-1:HLEN];
  assign lane1_req_o.op        = op_i;
  assign lane1_req_o.fmt       = fp_noncomp_pkg::FP16; // Upper lane only exists for FP16

  assign aux_o = '{dst_fmt: fmt_i, is_vector: vector_op};

endmodule

`default_nettype wire

// File: fp_lane_req_if.sv
// Op and fmt are raw bits in the package's operation_e and fp_format_e encodings
`default_nettype none

interface fp_lane_req_if #(
  parameter int unsigned Width = 32
);

  logic [Width-1:0] operand_a;
  logic [Width-1:0] operand_b;
  logic [2:0]       op;  // operation_e
  logic             fmt; // fp_format_e

  modport distributor (
    output operand_a,
    output operand_b,
    output op,
    output fmt
  );

  modport lane (
    input operand_a,
    input operand_b,
    input op,
    input fmt
  );

endinterface

`default_nettype wire

// File: fp_noncomp_pkg.sv
// Only FP32 and FP16 exist here; status flags other than NV are always zero for these ops
`default_nettype none

package fp_noncomp_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned FLEN      = 32;       // Operand and result word
  localparam int unsigned HLEN      = FLEN / 2; // One FP16 lane
  localparam int unsigned NUM_LANES = 2;
  localparam int unsigned TAG_BITS  = 8;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } operation_e;

  typedef struct packed {
    logic NV; // Invalid operation
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Travels with lane 0 so the packer knows how to assemble the word
  typedef struct packed {
    fp_format_e dst_fmt;
    logic       is_vector;
  } aux_t;

  typedef struct packed {
    logic [HLEN-1:0] result;
    status_t         status;
  } lane_res_t;

  typedef struct packed {
    logic [FLEN-1:0]     result; // FP16 results sit in the low half
    status_t             status;
    aux_t                aux;
    logic [TAG_BITS-1:0] tag;
  } lane0_res_t;

  localparam logic [FLEN-1:0] CANON_NAN32 = 32'h7fc0_0000;
  localparam logic [HLEN-1:0] CANON_NAN16 = 16'h7e00;

  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP16) ? HLEN : FLEN;
  endfunction

endpackage

`default_nettype wire
